// File: icache.f
hw/icache_pkg.sv
hw/icache_front.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/icache_top.sv
tb/icache_chk.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
// Testbench for the instruction cache. Runs directed fetches, flushes and
// bypasses, then random traffic with stalls on both sides, against a fill
// memory model and its own model of which lines the cache holds.

`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int unsigned LINE_COUNT    = 16;
    localparam int          DIRECTED_TXNS = 15;
    localparam int          RANDOM_TXNS   = 300;
    localparam int          TXN_COUNT     = DIRECTED_TXNS + RANDOM_TXNS;
    localparam int          LINE_SPAN     = 40;

    logic       clk_i;
    logic       rst_i;
    fetch_req_t fetch_req_i;
    logic       fetch_valid_i;
    logic       fetch_ready_o;
    fetch_rsp_t fetch_rsp_o;
    logic       fetch_rsp_valid_o;
    logic       fetch_rsp_ready_i;
    fill_req_t  fill_req_o;
    logic       fill_req_valid_o;
    logic       fill_req_ready_i;
    fill_rsp_t  fill_rsp_i;
    logic       fill_rsp_valid_i;
    logic       fill_rsp_ready_o;
    logic       flush_valid_i;
    logic       flush_ready_o;

    integer seed     = 56797;
    integer env_seed = 56797 + 1;
    int     cycle    = 0;
    logic   hold_rsp_ready = 1'b1;

    fetch_rsp_t exp_rsp_q[$];
    fill_req_t  exp_fill_q[$];
    bit         timed_q[$];
    int         accept_cycle_q[$];

    // Which lines the cache should hold, and the full line number in each
    bit                             model_valid [LINE_COUNT];
    logic [FETCH_AW-LINE_ALIGN-1:0] model_line  [LINE_COUNT];

    icache_top #(
        .LINE_COUNT ( LINE_COUNT )
    ) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(negedge clk_i) begin
        cycle <= cycle + 1;
    end

    // Every word holds its own byte address scrambled with a constant
    function automatic fetch_rsp_t ref_rsp(input logic [FETCH_AW-1:0] addr);
        fetch_rsp_t rsp;
        rsp.data  = {addr[FETCH_AW-1:FETCH_ALIGN], 2'b00} ^ 32'h5A5A0000;
        rsp.error = addr[12];
        return rsp;
    endfunction

    function automatic fill_rsp_t mem_line(input logic [FETCH_AW-1:0] line_addr);
        fill_rsp_t           line;
        logic [FETCH_AW-1:0] word_addr;
        for (int w = 0; w < LINE_WIDTH / FETCH_DW; w++) begin
            word_addr = line_addr + 4 * w;
            line.data[w*FETCH_DW +: FETCH_DW] = word_addr ^ 32'h5A5A0000;
        end
        line.error = line_addr[12];
        return line;
    endfunction

    function automatic bit predict_miss(input fetch_req_t req);
        int unsigned idx;
        idx = (req.addr >> LINE_ALIGN) % LINE_COUNT;
        return !req.cacheable || !model_valid[idx] ||
               (model_line[idx] != req.addr[FETCH_AW-1:LINE_ALIGN]);
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "Fail fetch_rsp_o: got data %h error %h, expected data %h error %h",
                got.data, got.error, exp.data, exp.error));
        end
    endtask

    task automatic check_fill(input fill_req_t got, input fill_req_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail fill_req_o: got addr %h, expected addr %h",
                                    got.addr, exp.addr));
        end
    endtask

    // Runs at the acceptance edge so the line model sees fetches in order
    task automatic record_accept(input fetch_req_t req);
        fill_req_t   fill;
        int unsigned idx;
        bit          miss;
        idx       = (req.addr >> LINE_ALIGN) % LINE_COUNT;
        miss      = predict_miss(req);
        fill.addr = {req.addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
        if (miss) begin
            exp_fill_q.push_back(fill);
        end
        if (miss && req.cacheable) begin
            model_valid[idx] = 1'b1;
            model_line[idx]  = req.addr[FETCH_AW-1:LINE_ALIGN];
        end
        exp_rsp_q.push_back(ref_rsp(req.addr));
        timed_q.push_back(hold_rsp_ready && !miss);
        accept_cycle_q.push_back(cycle);
    endtask

    task automatic do_fetch(input logic [FETCH_AW-1:0] addr, input logic cacheable);
        fetch_req_t req;
        req.addr      = addr;
        req.cacheable = cacheable;
        @(negedge clk_i);
        flush_valid_i = 1'b0;
        fetch_req_i   = req;
        fetch_valid_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!fetch_ready_o);
        record_accept(req);
    endtask

    task automatic do_flush();
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
        flush_valid_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!flush_ready_o);
        for (int i = 0; i < LINE_COUNT; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic drain_responses();
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
        flush_valid_i = 1'b0;
        while (exp_rsp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    // Fill memory model that answers each fill request after a random delay
    // and drives the ready gaps on both sides
    initial begin : fill_memory
        logic [FETCH_AW-1:0] fill_addr;
        bit                  pending;
        bit                  rsp_taken;
        int                  delay;
        fill_req_ready_i  = 1'b0;
        fill_rsp_i        = '0;
        fill_rsp_valid_i  = 1'b0;
        fetch_rsp_ready_i = 1'b0;
        fill_addr         = '0;
        pending           = 1'b0;
        delay             = 0;
        forever begin
            @(posedge clk_i);
            rsp_taken = fill_rsp_valid_i && fill_rsp_ready_o;
            if (fill_req_valid_o && fill_req_ready_i) begin
                pending   = 1'b1;
                fill_addr = fill_req_o.addr;
                delay     = {$random(env_seed)} % 5;
            end
            @(negedge clk_i);
            if (rsp_taken) begin
                fill_rsp_valid_i = 1'b0;
            end
            if (pending && !fill_rsp_valid_i) begin
                if (delay == 0) begin
                    fill_rsp_i       = mem_line(fill_addr);
                    fill_rsp_valid_i = 1'b1;
                    pending          = 1'b0;
                end else begin
                    delay--;
                end
            end
            fill_req_ready_i  = ({$random(env_seed)} % 4) != 0;
            fetch_rsp_ready_i = hold_rsp_ready || (({$random(env_seed)} % 10) < 7);
        end
    end

    always @(posedge clk_i) begin : compare_outputs
        bit timed;
        int accepted_at;
        if (!rst_i) begin
            if (i_dut.i_chk.fail_count != 0) begin
                stop_on_error("A bound protocol assertion failed");
            end
            if (fill_req_valid_o && fill_req_ready_i) begin
                if (exp_fill_q.size() == 0) begin
                    stop_on_error("The DUT made a fill request where a hit was expected");
                end
                check_fill(fill_req_o, exp_fill_q.pop_front());
            end
            if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
                if (exp_rsp_q.size() == 0) begin
                    stop_on_error("The DUT returned a response with no fetch outstanding");
                end
                if (exp_fill_q.size() != 0) begin
                    stop_on_error("A response came back before its predicted fill request");
                end
                check_rsp(fetch_rsp_o, exp_rsp_q.pop_front());
                timed       = timed_q.pop_front();
                accepted_at = accept_cycle_q.pop_front();
                if (timed && (cycle - accepted_at != 2)) begin
                    stop_on_error($sformatf("A hit was answered %0d cycles after acceptance, not 2",
                                            cycle - accepted_at));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (8 + 400 * TXN_COUNT) @(posedge clk_i);
        stop_on_error("Watchdog expired before the tests finished");
    end

    initial begin : stimulus
        int          line;
        int          word;
        logic        cacheable;
        rst_i         = 1'b1;
        fetch_req_i   = '0;
        fetch_valid_i = 1'b0;
        flush_valid_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // The directed part keeps the core always ready so hit latency is exact
        do_fetch(32'h0000_0208, 1'b1);
        do_fetch(32'h0000_020C, 1'b1);
        do_fetch(32'h0000_0314, 1'b0);
        do_fetch(32'h0000_0310, 1'b1);
        do_fetch(32'h0000_0318, 1'b1);
        do_fetch(32'h0000_0200, 1'b0);
        do_fetch(32'h0000_0204, 1'b1);
        do_flush();
        do_fetch(32'h0000_0208, 1'b1);
        do_fetch(32'h0000_1200, 1'b1);
        do_fetch(32'h0000_1204, 1'b1);
        do_fetch(32'h0000_0200, 1'b1);
        do_fetch(32'h0000_131C, 1'b1);
        do_fetch(32'h0000_131C, 1'b1);
        do_fetch(32'h0000_1000, 1'b0);
        hold_rsp_ready = 1'b0;
        drain_responses();

        // Random part over more lines than the cache holds
        for (int i = 0; i < RANDOM_TXNS; i++) begin
            if (({$random(seed)} % 100) < 5) begin
                do_flush();
            end else begin
                line      = {$random(seed)} % LINE_SPAN;
                word      = {$random(seed)} % 4;
                cacheable = ({$random(seed)} % 4) != 0;
                do_fetch(line * 32'h110 + word * 4, cacheable);
                if (({$random(seed)} % 4) == 0) begin
                    @(negedge clk_i);
                    fetch_valid_i = 1'b0;
                end
            end
        end
        drain_responses();
        repeat (20) @(posedge clk_i);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/icache_chk.sv
// Protocol checker for the instruction cache, bound into icache_top.
// Watches the DUT-driven handshakes, the ready rules while a response is
// pending and the alignment of fill addresses.

`timescale 1ns/1ps
`default_nettype none

module icache_chk import icache_pkg::*; (
    input logic       clk_i,
    input logic       rst_i,
    input fetch_rsp_t fetch_rsp_i,
    input logic       fetch_rsp_valid_i,
    input logic       fetch_rsp_ready_i,
    input fill_req_t  fill_req_i,
    input logic       fill_req_valid_i,
    input logic       fill_req_ready_i,
    input fetch_req_t refill_req_i,
    input logic       refill_valid_i,
    input logic       refill_ready_i,
    input logic       fetch_ready_i,
    input logic       flush_ready_i
);

    // Counts assertion failures so the testbench can stop on them
    int unsigned fail_count = 0;

    rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_rsp_valid_i && !fetch_rsp_ready_i |=> fetch_rsp_valid_i && $stable(fetch_rsp_i))
    else begin
        $error("Fetch response dropped or changed while stalled");
        fail_count++;
    end

    fill_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_req_valid_i && !fill_req_ready_i |=> fill_req_valid_i && $stable(fill_req_i))
    else begin
        $error("Fill request dropped or changed while stalled");
        fail_count++;
    end

    // Internal hand-off from the front end to the refill engine
    refill_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        refill_valid_i && !refill_ready_i |=> refill_valid_i && $stable(refill_req_i))
    else begin
        $error("Refill request dropped or changed while stalled");
        fail_count++;
    end

    ready_while_pending: assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_rsp_valid_i |-> !fetch_ready_i && !flush_ready_i)
    else begin
        $error("Fetch or flush ready raised while a response is pending");
        fail_count++;
    end

    fill_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_req_valid_i |-> fill_req_i.addr[LINE_ALIGN-1:0] == '0)
    else begin
        $error("Fill request address is not line aligned");
        fail_count++;
    end

endmodule

bind icache_top icache_chk i_chk (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .fetch_rsp_i       ( fetch_rsp_o       ),
    .fetch_rsp_valid_i ( fetch_rsp_valid_o ),
    .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
    .fill_req_i        ( fill_req_o        ),
    .fill_req_valid_i  ( fill_req_valid_o  ),
    .fill_req_ready_i  ( fill_req_ready_i  ),
    .refill_req_i      ( refill_req        ),
    .refill_valid_i    ( refill_valid      ),
    .refill_ready_i    ( refill_ready      ),
    .fetch_ready_i     ( fetch_ready_o     ),
    .flush_ready_i     ( flush_ready_o     )
);

`default_nettype wire

// File: hw/icache_top.sv
// Top level of the direct-mapped instruction cache with one fetch port.
// Sets the line count and connects front end, lookup arrays and refill engine.

`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic       clk_i,
    input  logic       rst_i,

    input  fetch_req_t fetch_req_i,
    input  logic       fetch_valid_i,
    output logic       fetch_ready_o,

    output fetch_rsp_t fetch_rsp_o,
    output logic       fetch_rsp_valid_o,
    input  logic       fetch_rsp_ready_i,

    output fill_req_t  fill_req_o,
    output logic       fill_req_valid_o,
    input  logic       fill_req_ready_i,

    input  fill_rsp_t  fill_rsp_i,
    input  logic       fill_rsp_valid_i,
    output logic       fill_rsp_ready_o,

    input  logic       flush_valid_i,
    output logic       flush_ready_o
);

    logic                lookup_valid;
    logic [FETCH_AW-1:0] lookup_addr;
    lookup_rsp_t         lookup_rsp;
    logic                lookup_rsp_valid;

    fetch_req_t          refill_req;
    logic                refill_valid;
    logic                refill_ready;
    fill_rsp_t           refill_rsp;
    logic                refill_done;

    line_write_t         line_write;
    logic                write_valid;
    logic                flush;

    icache_front i_front (
        .clk_i              ( clk_i             ),
        .rst_i              ( rst_i             ),
        .fetch_req_i        ( fetch_req_i       ),
        .fetch_valid_i      ( fetch_valid_i     ),
        .fetch_ready_o      ( fetch_ready_o     ),
        .fetch_rsp_o        ( fetch_rsp_o       ),
        .fetch_rsp_valid_o  ( fetch_rsp_valid_o ),
        .fetch_rsp_ready_i  ( fetch_rsp_ready_i ),
        .flush_valid_i      ( flush_valid_i     ),
        .flush_ready_o      ( flush_ready_o     ),
        .lookup_valid_o     ( lookup_valid      ),
        .lookup_addr_o      ( lookup_addr       ),
        .lookup_rsp_i       ( lookup_rsp        ),
        .lookup_rsp_valid_i ( lookup_rsp_valid  ),
        .refill_req_o       ( refill_req        ),
        .refill_valid_o     ( refill_valid      ),
        .refill_ready_i     ( refill_ready      ),
        .refill_rsp_i       ( refill_rsp        ),
        .refill_done_i      ( refill_done       ),
        .flush_o            ( flush             )
    );

    icache_lookup #(
        .LINE_COUNT ( LINE_COUNT )
    ) i_lookup (
        .clk_i              ( clk_i            ),
        .rst_i              ( rst_i            ),
        .lookup_valid_i     ( lookup_valid     ),
        .lookup_addr_i      ( lookup_addr      ),
        .lookup_rsp_o       ( lookup_rsp       ),
        .lookup_rsp_valid_o ( lookup_rsp_valid ),
        .write_i            ( line_write       ),
        .write_valid_i      ( write_valid      ),
        .flush_i            ( flush            )
    );

    icache_refill i_refill (
        .clk_i            ( clk_i            ),
        .rst_i            ( rst_i            ),
        .refill_req_i     ( refill_req       ),
        .refill_valid_i   ( refill_valid     ),
        .refill_ready_o   ( refill_ready     ),
        .refill_rsp_o     ( refill_rsp       ),
        .refill_done_o    ( refill_done      ),
        .write_o          ( line_write       ),
        .write_valid_o    ( write_valid      ),
        .fill_req_o       ( fill_req_o       ),
        .fill_req_valid_o ( fill_req_valid_o ),
        .fill_req_ready_i ( fill_req_ready_i ),
        .fill_rsp_i       ( fill_rsp_i       ),
        .fill_rsp_valid_i ( fill_rsp_valid_i ),
        .fill_rsp_ready_o ( fill_rsp_ready_o )
    );

endmodule

`default_nettype wire

// File: hw/icache_refill.sv
// Line-fill engine. Takes one miss or bypass fetch from the front end,
// issues a single line-aligned fill request and waits for the line.
// The line goes back to the front end, and cacheable lines are also
// written into the arrays.

`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,

    input  fetch_req_t  refill_req_i,
    input  logic        refill_valid_i,
    output logic        refill_ready_o,

    output fill_rsp_t   refill_rsp_o,
    output logic        refill_done_o,

    output line_write_t write_o,
    output logic        write_valid_o,

    output fill_req_t   fill_req_o,
    output logic        fill_req_valid_o,
    input  logic        fill_req_ready_i,

    input  fill_rsp_t   fill_rsp_i,
    input  logic        fill_rsp_valid_i,
    output logic        fill_rsp_ready_o
);

    refill_state_e state_q, state_d;
    fetch_req_t    req_q;
    fill_rsp_t     rsp_q;
    logic          done_q;
    logic          write_valid_q;
    logic          req_fire;
    logic          fill_fire;
    logic [FETCH_AW-1:0] line_addr;

    assign refill_ready_o = (state_q == REFILL_IDLE);
    assign req_fire       = refill_valid_i && refill_ready_o;

    // Drop the byte offset so the fill always asks for a whole line
    assign line_addr = {req_q.addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

    assign fill_req_o.addr  = line_addr;
    assign fill_req_valid_o = (state_q == REFILL_REQUEST);
    assign fill_rsp_ready_o = (state_q == REFILL_WAIT_FILL);
    assign fill_fire        = fill_rsp_valid_i && fill_rsp_ready_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            REFILL_IDLE: begin
                if (req_fire) begin
                    state_d = REFILL_REQUEST;
                end
            end
            REFILL_REQUEST: begin
                if (fill_req_ready_i) begin
                    state_d = REFILL_WAIT_FILL;
                end
            end
            REFILL_WAIT_FILL: begin
                if (fill_fire) begin
                    state_d = REFILL_IDLE;
                end
            end
            default: state_d = REFILL_IDLE;
        endcase
    end

    // Done and write pulses follow the fill response by one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= REFILL_IDLE;
            done_q        <= 1'b0;
            write_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            done_q        <= fill_fire;
            write_valid_q <= fill_fire && req_q.cacheable;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q <= refill_req_i;
        end
        if (fill_fire) begin
            rsp_q <= fill_rsp_i;
        end
    end

    assign refill_rsp_o  = rsp_q;
    assign refill_done_o = done_q;

    assign write_o.addr   = line_addr;
    assign write_o.data   = rsp_q.data;
    assign write_o.error  = rsp_q.error;
    assign write_valid_o  = write_valid_q;

endmodule

`default_nettype wire

// File: hw/icache_lookup.sv
// Direct-mapped tag and data arrays of the instruction cache.
// A lookup is always accepted and its result comes back one cycle later.
// Line writes from the refill engine and flushes take effect at their edge.

`timescale 1ns/1ps
`default_nettype none

module icache_lookup import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 16
) (
    input  logic                clk_i,
    input  logic                rst_i,

    input  logic                lookup_valid_i,
    input  logic [FETCH_AW-1:0] lookup_addr_i,
    output lookup_rsp_t         lookup_rsp_o,
    output logic                lookup_rsp_valid_o,

    input  line_write_t         write_i,
    input  logic                write_valid_i,

    input  logic                flush_i
);

    localparam int IDX_W = $clog2(LINE_COUNT);
    localparam int TAG_W = FETCH_AW - LINE_ALIGN - IDX_W;

    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] error_q;
    logic [TAG_W-1:0]      tag_q  [LINE_COUNT];
    logic [LINE_WIDTH-1:0] data_q [LINE_COUNT];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             rd_hit;

    lookup_rsp_t rsp_q;
    logic        rsp_valid_q;

    // Index sits right above the line offset, the tag takes the rest
    assign rd_idx = lookup_addr_i[LINE_ALIGN +: IDX_W];
    assign rd_tag = lookup_addr_i[FETCH_AW-1 -: TAG_W];
    assign wr_idx = write_i.addr[LINE_ALIGN +: IDX_W];
    assign wr_tag = write_i.addr[FETCH_AW-1 -: TAG_W];

    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // A flush clears the valid bits of every line at once
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (write_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_valid_i) begin
            tag_q[wr_idx]   <= wr_tag;
            data_q[wr_idx]  <= write_i.data;
            error_q[wr_idx] <= write_i.error;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= lookup_valid_i;
        end
    end

    // The result register carries the address along so the word can be picked
    always_ff @(posedge clk_i) begin
        if (lookup_valid_i) begin
            rsp_q.addr  <= lookup_addr_i;
            rsp_q.hit   <= rd_hit;
            rsp_q.data  <= data_q[rd_idx];
            rsp_q.error <= error_q[rd_idx];
        end
    end

    assign lookup_rsp_o       = rsp_q;
    assign lookup_rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// File: hw/icache_front.sv
// Request front end of the instruction cache. Accepts one fetch at a time,
// sends cacheable fetches to the lookup and bypass fetches to the refill
// engine, picks the addressed word out of the returned line and holds the
// response until the core takes it.

`timescale 1ns/1ps
`default_nettype none

module icache_front import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,

    input  fetch_req_t          fetch_req_i,
    input  logic                fetch_valid_i,
    output logic                fetch_ready_o,

    output fetch_rsp_t          fetch_rsp_o,
    output logic                fetch_rsp_valid_o,
    input  logic                fetch_rsp_ready_i,

    input  logic                flush_valid_i,
    output logic                flush_ready_o,

    output logic                lookup_valid_o,
    output logic [FETCH_AW-1:0] lookup_addr_o,
    input  lookup_rsp_t         lookup_rsp_i,
    input  logic                lookup_rsp_valid_i,

    output fetch_req_t          refill_req_o,
    output logic                refill_valid_o,
    input  logic                refill_ready_i,
    input  fill_rsp_t           refill_rsp_i,
    input  logic                refill_done_i,

    output logic                flush_o
);

    front_state_e state_q, state_d;
    fetch_req_t   req_q;
    fetch_rsp_t   rsp_q;
    fetch_rsp_t   sel_rsp;
    logic         refill_taken_q, refill_taken_d;
    logic         fetch_fire;
    logic         lookup_hit;
    logic         lookup_miss;
    logic         refill_rsp;
    logic [LINE_WIDTH-1:0]             sel_line;
    logic [LINE_ALIGN-FETCH_ALIGN-1:0] sel_word;

    // Flush only goes through while nothing is in flight, and it beats a fetch
    assign flush_ready_o = (state_q == FRONT_IDLE);
    assign flush_o       = flush_valid_i && flush_ready_o;
    assign fetch_ready_o = (state_q == FRONT_IDLE) && !flush_valid_i;
    assign fetch_fire    = fetch_valid_i && fetch_ready_o;

    // The lookup starts in the acceptance cycle
    assign lookup_valid_o = fetch_fire && fetch_req_i.cacheable;
    assign lookup_addr_o  = fetch_req_i.addr;

    assign lookup_hit  = (state_q == FRONT_LOOKUP) && lookup_rsp_valid_i && lookup_rsp_i.hit;
    assign lookup_miss = (state_q == FRONT_LOOKUP) && lookup_rsp_valid_i && !lookup_rsp_i.hit;
    assign refill_rsp  = (state_q == FRONT_REFILL) && refill_done_i;

    // A miss is handed to the refill engine straight from the lookup result
    assign refill_req_o   = req_q;
    assign refill_valid_o = lookup_miss || ((state_q == FRONT_REFILL) && !refill_taken_q);

    // One word selector serves both the looked-up and the filled line
    always_comb begin
        if (state_q == FRONT_LOOKUP) begin
            sel_line      = lookup_rsp_i.data;
            sel_word      = lookup_rsp_i.addr[LINE_ALIGN-1:FETCH_ALIGN];
            sel_rsp.error = lookup_rsp_i.error;
        end else begin
            sel_line      = refill_rsp_i.data;
            sel_word      = req_q.addr[LINE_ALIGN-1:FETCH_ALIGN];
            sel_rsp.error = refill_rsp_i.error;
        end
        sel_rsp.data = sel_line[sel_word*FETCH_DW +: FETCH_DW];
    end

    // Hits are served from the response register, refilled words pass through
    // in the done cycle and are held there if the core stalls
    assign fetch_rsp_valid_o = (state_q == FRONT_RESPOND) || refill_rsp;
    assign fetch_rsp_o       = (state_q == FRONT_RESPOND) ? rsp_q : sel_rsp;

    always_comb begin
        state_d        = state_q;
        refill_taken_d = refill_taken_q;
        unique case (state_q)
            FRONT_IDLE: begin
                refill_taken_d = 1'b0;
                if (fetch_fire) begin
                    state_d = fetch_req_i.cacheable ? FRONT_LOOKUP : FRONT_REFILL;
                end
            end
            FRONT_LOOKUP: begin
                if (lookup_hit) begin
                    state_d = FRONT_RESPOND;
                end else if (lookup_miss) begin
                    state_d        = FRONT_REFILL;
                    refill_taken_d = refill_ready_i;
                end
            end
            FRONT_REFILL: begin
                if (refill_valid_o && refill_ready_i) begin
                    refill_taken_d = 1'b1;
                end
                if (refill_done_i) begin
                    state_d = fetch_rsp_ready_i ? FRONT_IDLE : FRONT_RESPOND;
                end
            end
            FRONT_RESPOND: begin
                if (fetch_rsp_ready_i) begin
                    state_d = FRONT_IDLE;
                end
            end
            default: state_d = FRONT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q        <= FRONT_IDLE;
            refill_taken_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            refill_taken_q <= refill_taken_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_fire) begin
            req_q <= fetch_req_i;
        end
        if (lookup_hit || refill_rsp) begin
            rsp_q <= sel_rsp;
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_pkg.sv
// Shared widths, packed channel structs and FSM state types for the instruction cache.
// Every cache module and the testbench pull these in with a wildcard import.

`default_nettype none

package icache_pkg;

    // Fetch and fill addresses share one width
    localparam int FETCH_AW    = 32;
    localparam int FETCH_DW    = 32;
    localparam int LINE_WIDTH  = 128;
    localparam int LINE_ALIGN  = 4;
    localparam int FETCH_ALIGN = 2;

    // Fetch request from the core
    typedef struct packed {
        logic [FETCH_AW-1:0] addr;
        logic                cacheable;
    } fetch_req_t;

    // Fetch response to the core
    typedef struct packed {
        logic [FETCH_DW-1:0] data;
        logic                error;
    } fetch_rsp_t;

    // Line-fill request that always carries a line-aligned address
    typedef struct packed {
        logic [FETCH_AW-1:0] addr;
    } fill_req_t;

    typedef struct packed {
        logic [LINE_WIDTH-1:0] data;
        logic                  error;
    } fill_rsp_t;

    // Registered result of one array lookup
    typedef struct packed {
        logic [FETCH_AW-1:0]   addr;
        logic                  hit;
        logic [LINE_WIDTH-1:0] data;
        logic                  error;
    } lookup_rsp_t;

    // Line written back into the arrays after a cacheable refill
    typedef struct packed {
        logic [FETCH_AW-1:0]   addr;
        logic [LINE_WIDTH-1:0] data;
        logic                  error;
    } line_write_t;

    typedef enum logic [1:0] {
        FRONT_IDLE,
        FRONT_LOOKUP,
        FRONT_REFILL,
        FRONT_RESPOND
    } front_state_e;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_REQUEST,
        REFILL_WAIT_FILL
    } refill_state_e;

endpackage

`default_nettype wire
